//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP      := lsu_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- include/lsu_params.svh
// --------------------------------------------------
// sizing macros for the load/store unit slice
// lane count, data width and tag field widths
// include wherever a width or depth is needed
// --------------------------------------------------
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// lanes served per instruction
`define LSU_NUM_LANES 4

// data width per lane, one word of 4 bytes
`define LSU_XLEN 32

// immediate offset added to the base register
`define LSU_OFFSET_W 12

// warp id width
`define LSU_NW_W 2

// destination register index width
`define LSU_NR_W 5

// byte offset bits inside a word
`define LSU_ALIGN_W 2

// word address, byte address minus the alignment bits
`define LSU_ADDR_W 30

// entries per elastic buffer
`define LSU_BUF_DEPTH 2

`endif

//--- source/lsu_commit_arb.sv
// --------------------------------------------------
// merges load and store commit streams
// round-robin pick, one grant per cycle, result
// held in a one-entry output register
// --------------------------------------------------
`timescale 1ns/1ps

module lsu_commit_arb (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        load_valid,
    input  lsu_pipe_pkg::lsu_commit_t   load_data,
    output logic                        load_ready,
    input  logic                        store_valid,
    input  lsu_pipe_pkg::lsu_commit_t   store_data,
    output logic                        store_ready,
    output logic                        commit_valid,
    output lsu_pipe_pkg::lsu_commit_t   commit,
    input  logic                        commit_ready
);
    logic prefer_store;
    logic out_load;
    logic pick_store;
    logic any_valid;

    // output register free or draining this cycle
    assign out_load = !commit_valid || commit_ready;

    // store wins when alone or when it holds priority
    assign pick_store = store_valid && (!load_valid || prefer_store);
    assign any_valid  = load_valid || store_valid;

    assign load_ready  = out_load && !pick_store;
    assign store_ready = out_load && pick_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            prefer_store <= 1'b0;
        end else if (out_load) begin
            commit_valid <= any_valid;
            // priority moves to the other side after a grant
            if (any_valid) begin
                prefer_store <= !pick_store;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load && any_valid) begin
            commit <= pick_store ? store_data : load_data;
        end
    end

endmodule

//--- source/lsu_elastic_buf.sv
// --------------------------------------------------
// small valid/ready FIFO between two stages
// payload type set per instance; output valid one
// cycle after the input transfer, empty after reset
// --------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_elastic_buf #(
    parameter type payload_t = logic,
    parameter int  depth     = `LSU_BUF_DEPTH
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  payload_t    in_data,
    output logic        in_ready,
    output logic        out_valid,
    output payload_t    out_data,
    input  logic        out_ready
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           entries [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               push;
    logic               pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign in_ready  = (count != cnt_w'(depth));
    assign out_valid = (count != '0);
    assign out_data  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count alone
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

//--- source/lsu_mem_pkg.sv
// --------------------------------------------------
// memory side types of the load/store unit
// request, response and the tag echoed by memory
// --------------------------------------------------
`include "lsu_params.svh"

package lsu_mem_pkg;

    import lsu_pipe_pkg::*;

    // context carried through memory, 50 bits
    typedef struct packed {
        logic [`LSU_NW_W-1:0]                           wid;
        logic [`LSU_XLEN-1:0]                           pc;
        logic [`LSU_NR_W-1:0]                           rd;
        lsu_fmt_e                                       fmt;
        // byte offset per lane, needed to pick load data
        logic [`LSU_NUM_LANES-1:0][`LSU_ALIGN_W-1:0]    align;
    } lsu_mem_tag_t;

    // one request for all active lanes
    typedef struct packed {
        logic                                           rw;
        logic [`LSU_NUM_LANES-1:0]                      mask;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN/8-1:0]     byteen;
        logic [`LSU_NUM_LANES-1:0][`LSU_ADDR_W-1:0]     addr;
        // store data already shifted into byte lanes
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]       data;
        lsu_mem_tag_t                                   tag;
    } lsu_mem_req_t;

    // load response, whole words per lane
    typedef struct packed {
        logic [`LSU_NUM_LANES-1:0]                      mask;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]       data;
        lsu_mem_tag_t                                   tag;
    } lsu_mem_rsp_t;

endpackage

//--- source/lsu_pipe_pkg.sv
// --------------------------------------------------
// pipeline side types of the load/store unit
// execute stage request and commit record
// import into modules that build or read these
// --------------------------------------------------
`include "lsu_params.svh"

package lsu_pipe_pkg;

    // access format, low two bits give the size
    // bit 2 marks zero extension on loads
    typedef enum logic [2:0] {
        fmt_b  = 3'b000,
        fmt_h  = 3'b001,
        fmt_w  = 3'b010,
        fmt_bu = 3'b100,
        fmt_hu = 3'b101
    } lsu_fmt_e;

    // one instruction from the execute stage
    typedef struct packed {
        logic [`LSU_NW_W-1:0]                       wid;
        logic [`LSU_XLEN-1:0]                       pc;
        logic [`LSU_NUM_LANES-1:0]                  mask;
        logic [`LSU_NR_W-1:0]                       rd;
        logic                                       is_store;
        lsu_fmt_e                                   fmt;
        logic [`LSU_OFFSET_W-1:0]                   offset;
        // base address per lane
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   rs1_data;
        // store data per lane, low bytes used
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   rs2_data;
    } lsu_exec_req_t;

    // one record towards writeback
    typedef struct packed {
        logic [`LSU_NW_W-1:0]                       wid;
        logic [`LSU_XLEN-1:0]                       pc;
        logic [`LSU_NUM_LANES-1:0]                  mask;
        logic [`LSU_NR_W-1:0]                       rd;
        // set for loads only
        logic                                       wb;
        logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   data;
    } lsu_commit_t;

    // access size in log2 bytes
    function automatic logic [1:0] fmt_size(input lsu_fmt_e fmt);
        return fmt[1:0];
    endfunction

endpackage

//--- source/lsu_req_issue.sv
// --------------------------------------------------
// request side of the load/store unit
// address generation, byte enables, store alignment
// also drives the execute / memory / store buffer
// handshake, all combinational
// --------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_req_issue (
    input  logic                        exec_valid,
    input  lsu_pipe_pkg::lsu_exec_req_t exec_req,
    output logic                        exec_ready,
    output logic                        mem_req_valid,
    output lsu_mem_pkg::lsu_mem_req_t   mem_req,
    input  logic                        mem_req_ready,
    output logic                        store_valid,
    output lsu_pipe_pkg::lsu_commit_t   store_commit,
    input  logic                        store_ready
);
    import lsu_pipe_pkg::*;
    import lsu_mem_pkg::*;

    localparam int byte_w = `LSU_XLEN / 8;

    logic [`LSU_XLEN-1:0]                           offset_sext;
    logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]       full_addr;
    logic [`LSU_NUM_LANES-1:0][`LSU_ALIGN_W-1:0]    align;
    logic [`LSU_NUM_LANES-1:0][byte_w-1:0]          byteen;
    logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]       st_data;
    logic [1:0]                                     size;
    logic                                           is_store;

    assign is_store = exec_req.is_store;
    assign size     = fmt_size(exec_req.fmt);

    // immediate is signed
    assign offset_sext = {{(`LSU_XLEN - `LSU_OFFSET_W){exec_req.offset[`LSU_OFFSET_W-1]}},
                          exec_req.offset};

    always_comb begin
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            full_addr[i] = exec_req.rs1_data[i] + offset_sext;
            align[i]     = full_addr[i][`LSU_ALIGN_W-1:0];
            // size pattern moved up to the addressed byte
            case (size)
                2'd0:    byteen[i] = byte_w'(1) << align[i];
                2'd1:    byteen[i] = byte_w'(2'b11) << {align[i][1], 1'b0};
                default: byteen[i] = {byte_w{1'b1}};
            endcase
            // low bytes of rs2 into lane position
            st_data[i] = exec_req.rs2_data[i] << {align[i], 3'b000};
        end
    end

    always_comb begin
        mem_req.rw     = is_store;
        mem_req.mask   = exec_req.mask;
        mem_req.byteen = byteen;
        mem_req.data   = st_data;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            // misaligned accesses are not handled
            mem_req.addr[i] = full_addr[i][`LSU_XLEN-1:`LSU_ALIGN_W];
        end
        mem_req.tag.wid   = exec_req.wid;
        mem_req.tag.pc    = exec_req.pc;
        mem_req.tag.rd    = exec_req.rd;
        mem_req.tag.fmt   = exec_req.fmt;
        mem_req.tag.align = align;
    end

    // stores commit early, nothing to write back
    always_comb begin
        store_commit      = '0;
        store_commit.wid  = exec_req.wid;
        store_commit.pc   = exec_req.pc;
        store_commit.mask = exec_req.mask;
        store_commit.wb   = 1'b0;
    end

    // a store needs memory and the store buffer in the same cycle
    assign exec_ready    = mem_req_ready && (!is_store || store_ready);
    assign mem_req_valid = exec_valid && (!is_store || store_ready);
    assign store_valid   = exec_valid && is_store && mem_req_ready;

endmodule

//--- source/lsu_rsp_format.sv
// --------------------------------------------------
// load response formatting
// unpacks the echoed tag and extracts the loaded
// byte, halfword or word per lane, with extension
// --------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_rsp_format (
    input  lsu_mem_pkg::lsu_mem_rsp_t   mem_rsp,
    output lsu_pipe_pkg::lsu_commit_t   rsp_commit
);
    import lsu_pipe_pkg::*;
    import lsu_mem_pkg::*;

    lsu_mem_tag_t                               rsp_tag;
    logic [`LSU_NUM_LANES-1:0][`LSU_XLEN-1:0]   rsp_data;

    assign rsp_tag = mem_rsp.tag;

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        logic [`LSU_XLEN-1:0]   word;
        logic [15:0]            half;
        logic [7:0]             byte_sel;

        assign word     = mem_rsp.data[i];
        // upper half on align bit 1, upper byte on align bit 0
        assign half     = rsp_tag.align[i][1] ? word[31:16] : word[15:0];
        assign byte_sel = rsp_tag.align[i][0] ? half[15:8] : half[7:0];

        always_comb begin
            case (rsp_tag.fmt)
                fmt_b:   rsp_data[i] = {{(`LSU_XLEN - 8){byte_sel[7]}}, byte_sel};
                fmt_h:   rsp_data[i] = {{(`LSU_XLEN - 16){half[15]}}, half};
                fmt_bu:  rsp_data[i] = {{(`LSU_XLEN - 8){1'b0}}, byte_sel};
                fmt_hu:  rsp_data[i] = {{(`LSU_XLEN - 16){1'b0}}, half};
                // full word, nothing to extend
                default: rsp_data[i] = word;
            endcase
        end
    end

    // load result goes to writeback
    always_comb begin
        rsp_commit.wid  = rsp_tag.wid;
        rsp_commit.pc   = rsp_tag.pc;
        rsp_commit.mask = mem_rsp.mask;
        rsp_commit.rd   = rsp_tag.rd;
        rsp_commit.wb   = 1'b1;
        rsp_commit.data = rsp_data;
    end

endmodule

//--- source/lsu_slice.sv
// --------------------------------------------------
// load/store unit slice, top level
// execute port in, memory request/response ports,
// commit port out; issue, format, buffers, arbiter
// --------------------------------------------------
`timescale 1ns/1ps

module lsu_slice (
    input  logic                        clk,
    input  logic                        reset,
    // execute stage
    input  logic                        exec_valid,
    input  lsu_pipe_pkg::lsu_exec_req_t exec_req,
    output logic                        exec_ready,
    // memory request
    output logic                        mem_req_valid,
    output lsu_mem_pkg::lsu_mem_req_t   mem_req,
    input  logic                        mem_req_ready,
    // memory response
    input  logic                        mem_rsp_valid,
    input  lsu_mem_pkg::lsu_mem_rsp_t   mem_rsp,
    output logic                        mem_rsp_ready,
    // commit
    output logic                        commit_valid,
    output lsu_pipe_pkg::lsu_commit_t   commit,
    input  logic                        commit_ready
);
    import lsu_pipe_pkg::*;

    // store path into the no-response buffer
    logic           issue_store_valid;
    lsu_commit_t    issue_store_commit;
    logic           issue_store_ready;

    // formatted load result
    lsu_commit_t    rsp_commit;

    // buffer outputs towards the arbiter
    logic           load_out_valid;
    lsu_commit_t    load_out_data;
    logic           load_out_ready;
    logic           store_out_valid;
    lsu_commit_t    store_out_data;
    logic           store_out_ready;

    lsu_req_issue req_issue (
        .exec_valid     (exec_valid),
        .exec_req       (exec_req),
        .exec_ready     (exec_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .store_valid    (issue_store_valid),
        .store_commit   (issue_store_commit),
        .store_ready    (issue_store_ready)
    );

    lsu_rsp_format rsp_format (
        .mem_rsp        (mem_rsp),
        .rsp_commit     (rsp_commit)
    );

    // load buffer sets mem_rsp_ready from its free space
    lsu_elastic_buf #(
        .payload_t      (lsu_commit_t)
    ) load_buf (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (mem_rsp_valid),
        .in_data        (rsp_commit),
        .in_ready       (mem_rsp_ready),
        .out_valid      (load_out_valid),
        .out_data       (load_out_data),
        .out_ready      (load_out_ready)
    );

    lsu_elastic_buf #(
        .payload_t      (lsu_commit_t)
    ) store_buf (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (issue_store_valid),
        .in_data        (issue_store_commit),
        .in_ready       (issue_store_ready),
        .out_valid      (store_out_valid),
        .out_data       (store_out_data),
        .out_ready      (store_out_ready)
    );

    lsu_commit_arb commit_arb (
        .clk            (clk),
        .reset          (reset),
        .load_valid     (load_out_valid),
        .load_data      (load_out_data),
        .load_ready     (load_out_ready),
        .store_valid    (store_out_valid),
        .store_data     (store_out_data),
        .store_ready    (store_out_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready)
    );

endmodule

//--- tb/lsu_clk_gen.sv
// --------------------------------------------------
// clock and reset for the lsu testbench
// 10 ns clock, reset high for the first 10 cycles
// --------------------------------------------------
`timescale 1ns/1ps

module lsu_clk_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after the 10th rising edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- tb/lsu_tb.sv
// --------------------------------------------------
// testbench for the load/store unit slice
// random loads and stores against a memory model,
// responses reordered, commits matched by wid and pc
// --------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_tb;
    import lsu_pipe_pkg::*;
    import lsu_mem_pkg::*;

    // stores, loads, reordered loads, mixed under back-pressure
    localparam int n_instr     = 40 + 60 + 30 + 40;
    localparam int cycle_limit = 40 * n_instr + 200;

    logic           clk;
    logic           reset;
    logic           exec_valid;
    lsu_exec_req_t  exec_req;
    logic           exec_ready;
    logic           mem_req_valid;
    lsu_mem_req_t   mem_req;
    logic           mem_req_ready;
    logic           mem_rsp_valid;
    lsu_mem_rsp_t   mem_rsp;
    logic           mem_rsp_ready;
    logic           commit_valid;
    lsu_commit_t    commit;
    logic           commit_ready;

    // word memory, 1 KiB of byte addresses
    logic [31:0]    mem [256];
    lsu_commit_t    exp_q [$];
    lsu_mem_rsp_t   pend_q [$];
    int             due_q [$];
    int             cycle;
    int             issued;
    int             commits;
    int             err_count;
    int             tests_failed;
    int             reorder_seen;
    int             max_delay;
    logic [31:0]    next_pc;
    logic [31:0]    last_rsp_pc;
    logic           bp_mode;
    logic           rsp_fired;

    lsu_clk_gen clk_gen (
        .clk    (clk),
        .reset  (reset)
    );

    lsu_slice dut0 (
        .clk            (clk),
        .reset          (reset),
        .exec_valid     (exec_valid),
        .exec_req       (exec_req),
        .exec_ready     (exec_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .commit_ready   (commit_ready)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("error: %s got %h expected %h", name, got, want);
            err_count++;
        end
    endtask

    // selected byte or half moved down, then extended by format
    function automatic logic [31:0] load_value(input logic [31:0] word,
                                               input logic [1:0] al, input lsu_fmt_e fmt);
        logic [31:0] sh;
        sh = word >> (8 * al);
        case (fmt)
            fmt_b:   return {{24{sh[7]}}, sh[7:0]};
            fmt_h:   return {{16{sh[15]}}, sh[15:0]};
            fmt_bu:  return {24'd0, sh[7:0]};
            fmt_hu:  return {16'd0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic lsu_fmt_e pick_fmt(input int sel);
        case (sel)
            0:       return fmt_b;
            1:       return fmt_h;
            2:       return fmt_w;
            3:       return fmt_bu;
            default: return fmt_hu;
        endcase
    endfunction

    function automatic lsu_exec_req_t make_req(input logic st, input lsu_fmt_e fmt,
                                               input logic [31:0] pc);
        lsu_exec_req_t  r;
        logic [31:0]    off;
        logic [31:0]    addr;
        logic [1:0]     al;
        r          = '0;
        r.wid      = 2'($urandom);
        r.pc       = pc;
        r.mask     = 4'($urandom % 15 + 1);
        r.rd       = 5'($urandom);
        r.is_store = st;
        r.fmt      = fmt;
        r.offset   = 12'($urandom);
        off        = {{20{r.offset[11]}}, r.offset};
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            // naturally aligned target, base backed off by the offset
            al = 2'($urandom);
            if (fmt[1:0] == 2'd1) begin
                al[0] = 1'b0;
            end
            if (fmt[1:0] == 2'd2) begin
                al = 2'd0;
            end
            addr          = {22'd0, 8'($urandom), al};
            r.rs1_data[i] = addr - off;
            r.rs2_data[i] = $urandom;
        end
        return r;
    endfunction

    // request fires on the coming edge, checked against exec_req
    task automatic take_request();
        lsu_commit_t    exp;
        lsu_mem_rsp_t   rsp;
        logic [31:0]    addr;
        logic [31:0]    sdata;
        logic [31:0]    bmask;
        logic [3:0]     be;
        logic [1:0]     al;
        exp      = '0;
        rsp      = '0;
        exp.wid  = exec_req.wid;
        exp.pc   = exec_req.pc;
        exp.mask = exec_req.mask;
        exp.wb   = !exec_req.is_store;
        exp.rd   = exec_req.is_store ? '0 : exec_req.rd;
        rsp.mask = mem_req.mask;
        rsp.tag  = mem_req.tag;
        check_value("mem_req.rw", 32'(mem_req.rw), 32'(exec_req.is_store));
        check_value("mem_req.mask", 32'(mem_req.mask), 32'(exec_req.mask));
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            addr = exec_req.rs1_data[i] + {{20{exec_req.offset[11]}}, exec_req.offset};
            al   = addr[1:0];
            // inactive lanes return junk
            rsp.data[i] = $urandom;
            if (exec_req.mask[i]) begin
                check_value($sformatf("mem_req.addr[%0d]", i), 32'(mem_req.addr[i]),
                            32'(addr[31:2]));
                if (exec_req.is_store) begin
                    case (exec_req.fmt[1:0])
                        2'd0:    be = 4'b0001 << al;
                        2'd1:    be = 4'b0011 << al;
                        default: be = 4'b1111;
                    endcase
                    sdata = exec_req.rs2_data[i] << (8 * al);
                    for (int b = 0; b < 4; b++) begin
                        bmask[8*b +: 8] = {8{be[b]}};
                    end
                    check_value($sformatf("mem_req.byteen[%0d]", i),
                                32'(mem_req.byteen[i]), 32'(be));
                    check_value($sformatf("mem_req.data[%0d]", i),
                                mem_req.data[i] & bmask, sdata & bmask);
                    for (int b = 0; b < 4; b++) begin
                        if (be[b]) begin
                            mem[addr[9:2]][8*b +: 8] = sdata[8*b +: 8];
                        end
                    end
                end else begin
                    rsp.data[i] = mem[addr[9:2]];
                    exp.data[i] = load_value(mem[addr[9:2]], al, exec_req.fmt);
                end
            end
        end
        exp_q.push_back(exp);
        issued++;
        if (!exec_req.is_store) begin
            pend_q.push_back(rsp);
            due_q.push_back(cycle + 1 + int'($urandom % max_delay));
        end
    endtask

    task automatic check_commit();
        lsu_commit_t    exp;
        int             idx;
        idx = -1;
        commits++;
        for (int k = 0; k < exp_q.size(); k++) begin
            if (idx < 0 && exp_q[k].wid == commit.wid && exp_q[k].pc == commit.pc) begin
                idx = k;
            end
        end
        if (idx < 0) begin
            $display("commit for warp %0d at pc %h matches no outstanding instruction",
                     commit.wid, commit.pc);
            err_count++;
            return;
        end
        exp = exp_q[idx];
        exp_q.delete(idx);
        check_value("commit.wb", 32'(commit.wb), 32'(exp.wb));
        check_value("commit.mask", 32'(commit.mask), 32'(exp.mask));
        check_value("commit.rd", 32'(commit.rd), 32'(exp.rd));
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            if (exp.mask[i]) begin
                check_value($sformatf("commit.data[%0d]", i), commit.data[i], exp.data[i]);
            end
        end
    endtask

    // random pick among responses whose delay has run out
    task automatic send_response();
        int n;
        int start;
        int pick;
        n    = pend_q.size();
        pick = -1;
        if (n == 0) begin
            return;
        end
        start = int'($urandom % n);
        for (int j = 0; j < n; j++) begin
            if (pick < 0 && due_q[(start + j) % n] <= cycle) begin
                pick = (start + j) % n;
            end
        end
        if (pick >= 0) begin
            mem_rsp       = pend_q[pick];
            mem_rsp_valid = 1'b1;
            pend_q.delete(pick);
            due_q.delete(pick);
        end
    endtask

    // sampled mid-cycle, values hold until the next edge
    always @(negedge clk) begin
        if (!reset) begin
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                rsp_fired = 1'b1;
                if (mem_rsp.tag.pc < last_rsp_pc) begin
                    reorder_seen++;
                end
                last_rsp_pc = mem_rsp.tag.pc;
            end
            if (mem_req_valid && mem_req_ready) begin
                take_request();
            end
        end
    end

    // memory side and commit stalls, 1 ns after the edge
    always begin
        @(posedge clk);
        #1;
        mem_req_ready = ($urandom % 8) != 0;
        if (bp_mode) begin
            // long stall, short window
            commit_ready = (cycle % 28) >= 25;
        end else begin
            commit_ready = ($urandom % 8) != 0;
        end
        if (rsp_fired) begin
            mem_rsp_valid = 1'b0;
            rsp_fired     = 1'b0;
        end
        if (!mem_rsp_valid) begin
            send_response();
        end
    end

    // kind 0 stores, 1 loads, 2 mixed
    task automatic issue_batch(input int n, input int kind);
        logic       st;
        lsu_fmt_e   fmt;
        for (int k = 0; k < n; k++) begin
            st  = (kind == 0) || (kind == 2 && ($urandom % 2) == 0);
            fmt = st ? pick_fmt(int'($urandom % 3)) : pick_fmt(int'($urandom % 5));
            exec_req   = make_req(st, fmt, next_pc);
            next_pc    = next_pc + 4;
            exec_valid = 1'b1;
            @(negedge clk);
            while (!exec_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            exec_valid = 1'b0;
            if (($urandom % 4) == 0) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic check_idle();
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
    endtask

    task automatic report_test(input string name, input int err0, input int com0,
                               input int iss0);
        if (commits - com0 != issued - iss0) begin
            $display("%s: %0d commits for %0d issued instructions", name,
                     commits - com0, issued - iss0);
            err_count++;
        end
        if (err_count == err0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - err0);
        end
    endtask

    initial begin
        cycle = 0;
        while (cycle < cycle_limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run still busy after %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int err0;
        int com0;
        int iss0;
        void'($urandom(32'hbaa5_0223));
        exec_valid    = 1'b0;
        exec_req      = '0;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        commit_ready  = 1'b1;
        issued        = 0;
        commits       = 0;
        err_count     = 0;
        tests_failed  = 0;
        reorder_seen  = 0;
        max_delay     = 6;
        next_pc       = 32'h0000_1000;
        last_rsp_pc   = '0;
        bp_mode       = 1'b0;
        rsp_fired     = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) + 1) * 32'h9e37_79b9 ^ (32'(i) << 24);
        end

        // reset and the cycle after it
        err0 = err_count;
        do begin
            @(negedge clk);
            check_idle();
        end while (reset);
        @(negedge clk);
        check_idle();
        // buffers empty, memory ready, so both ready lines are high
        check_value("mem_rsp_ready", 32'(mem_rsp_ready), 32'd1);
        check_value("exec_ready", 32'(exec_ready), 32'd1);
        report_test("reset", err0, 0, 0);
        @(posedge clk);
        #1;

        err0 = err_count;
        com0 = commits;
        iss0 = issued;
        issue_batch(40, 0);
        wait_drain();
        report_test("store formatting", err0, com0, iss0);

        err0 = err_count;
        com0 = commits;
        iss0 = issued;
        issue_batch(60, 1);
        wait_drain();
        report_test("load extension", err0, com0, iss0);

        // longer delays so responses overtake each other
        err0         = err_count;
        com0         = commits;
        iss0         = issued;
        max_delay    = 24;
        reorder_seen = 0;
        issue_batch(30, 1);
        wait_drain();
        max_delay = 6;
        if (reorder_seen == 0) begin
            $display("no memory response came back out of order");
            err_count++;
        end
        report_test("out-of-order responses", err0, com0, iss0);

        err0    = err_count;
        com0    = commits;
        iss0    = issued;
        bp_mode = 1'b1;
        issue_batch(40, 2);
        wait_drain();
        bp_mode = 1'b0;
        if (commits != issued) begin
            $display("%0d commits in total for %0d issued instructions", commits, issued);
            err_count++;
        end
        report_test("back-pressure", err0, com0, iss0);

        $display("summary: 5 tests, %0d failed, %0d errors, %0d issued, %0d committed",
                 tests_failed, err_count, issued, commits);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
source/lsu_pipe_pkg.sv
source/lsu_mem_pkg.sv
source/lsu_req_issue.sv
source/lsu_rsp_format.sv
source/lsu_elastic_buf.sv
source/lsu_commit_arb.sv
source/lsu_slice.sv
tb/lsu_clk_gen.sv
tb/lsu_tb.sv
